//--- rtl/sfr_map_pkg.sv
package sfr_map_pkg;

    // ------------------------------------------------------------------------
    // Data widths
    // ------------------------------------------------------------------------
    localparam int DATA_WIDTH = 8;
    localparam int WORD_WIDTH = 16;
    localparam int ADDR_WIDTH = 8;
    localparam int STEP_WIDTH = 3;

    typedef logic [DATA_WIDTH-1:0]        byte_t;
    typedef logic [WORD_WIDTH-1:0]        word_t;
    typedef logic [ADDR_WIDTH-1:0]        sfr_addr_t;
    // Stack move amount, -4 to +3
    typedef logic signed [STEP_WIDTH-1:0] stack_step_t;

    // ------------------------------------------------------------------------
    // Register addresses
    // ------------------------------------------------------------------------
    localparam sfr_addr_t ACC_ADDR    = 8'hE0;
    localparam sfr_addr_t B_ADDR      = 8'hF0;
    localparam sfr_addr_t PSW_ADDR    = 8'hD0;

    localparam sfr_addr_t SPL_ADDR    = 8'h81;
    localparam sfr_addr_t SPH_ADDR    = 8'h85;
    localparam sfr_addr_t DPL_ADDR    = 8'h82;
    localparam sfr_addr_t DPH_ADDR    = 8'h83;

    // Port output latches
    localparam sfr_addr_t P0_ADDR     = 8'h80;
    localparam sfr_addr_t P1_ADDR     = 8'h90;
    localparam sfr_addr_t P2_ADDR     = 8'hA0;
    localparam sfr_addr_t P3_ADDR     = 8'hB0;

    // Port direction registers, 1 means output
    localparam sfr_addr_t P0_DIR_ADDR = 8'hC8;
    localparam sfr_addr_t P1_DIR_ADDR = 8'hC9;
    localparam sfr_addr_t P2_DIR_ADDR = 8'hCA;
    localparam sfr_addr_t P3_DIR_ADDR = 8'hCB;

    // ------------------------------------------------------------------------
    // Reset values
    // ------------------------------------------------------------------------
    localparam word_t SP_RESET = 16'h0007;

endpackage

//--- rtl/core_ctl_pkg.sv
package core_ctl_pkg;

    // ------------------------------------------------------------------------
    // Inputs from the core
    // ------------------------------------------------------------------------

    // Single register write strobe
    typedef struct packed {
        logic                   we;
        sfr_map_pkg::sfr_addr_t addr;
        sfr_map_pkg::byte_t     data;
    } sfr_write_t;

    // Flags produced by the ALU
    typedef struct packed {
        logic cy;
        logic ac;
        logic ov;
    } alu_flags_t;

    // Direct updates of ACC, PSW and SP
    typedef struct packed {
        logic                     load_a;
        sfr_map_pkg::byte_t       a_value;
        logic                     psw_flag_update;
        logic                     rlc_a;
        logic                     rrc_a;
        logic                     cy_update;
        sfr_map_pkg::stack_step_t stack_move;
    } core_update_t;

    typedef struct packed {
        logic               load;
        logic               inc;
        sfr_map_pkg::word_t value;
    } dptr_update_t;

    // ------------------------------------------------------------------------
    // Register views
    // ------------------------------------------------------------------------

    // Values the registers will hold after the current edge
    typedef struct packed {
        sfr_map_pkg::byte_t acc;
        sfr_map_pkg::byte_t b;
        sfr_map_pkg::byte_t psw;
        sfr_map_pkg::word_t dptr;
        sfr_map_pkg::byte_t spl;
    } sfr_next_t;

    // Index 0 is P0
    typedef struct packed {
        sfr_map_pkg::byte_t [3:0] latch;
        sfr_map_pkg::byte_t [3:0] dir;
    } port_view_t;

endpackage

//--- rtl/acc_psw_regs.sv
module acc_psw_regs (
    input  logic                      clk,
    input  logic                      reset_n,
    input  core_ctl_pkg::sfr_write_t   write,
    input  core_ctl_pkg::alu_flags_t   flags,
    input  core_ctl_pkg::core_update_t core_ctl,
    output sfr_map_pkg::byte_t        acc,
    output sfr_map_pkg::byte_t        b,
    output sfr_map_pkg::byte_t        psw,
    output sfr_map_pkg::byte_t        acc_next,
    output sfr_map_pkg::byte_t        b_next,
    output sfr_map_pkg::byte_t        psw_next
);

    // Bit 0 of PSW is parity and is never stored
    logic [7:1] psw_hi;
    logic [7:1] psw_hi_next;
    logic       acc_we;
    logic       b_we;
    logic       psw_we;

    assign acc_we = write.we && (write.addr == sfr_map_pkg::ACC_ADDR);
    assign b_we   = write.we && (write.addr == sfr_map_pkg::B_ADDR);
    assign psw_we = write.we && (write.addr == sfr_map_pkg::PSW_ADDR);

    // ------------------------------------------------------------------------
    // Next values
    // ------------------------------------------------------------------------

    // Core load wins over a register write
    always_comb begin
        if (core_ctl.load_a) begin
            acc_next = core_ctl.a_value;
        end else if (acc_we) begin
            acc_next = write.data;
        end else begin
            acc_next = acc;
        end
    end

    assign b_next = b_we ? write.data : b;

    // Rotates take the carry from the ACC before the edge
    always_comb begin
        psw_hi_next = psw_hi;
        if (psw_we) begin
            psw_hi_next = write.data[7:1];
        end else if (core_ctl.psw_flag_update) begin
            psw_hi_next[7] = flags.cy;
            psw_hi_next[6] = flags.ac;
            psw_hi_next[2] = flags.ov;
        end else if (core_ctl.rlc_a) begin
            psw_hi_next[7] = acc[7];
        end else if (core_ctl.rrc_a) begin
            psw_hi_next[7] = acc[0];
        end else if (core_ctl.cy_update) begin
            psw_hi_next[7] = flags.cy;
        end
    end

    assign psw_next = {psw_hi_next, ^acc_next};
    assign psw      = {psw_hi, ^acc};

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc    <= '0;
            b      <= '0;
            psw_hi <= '0;
        end else begin
            acc    <= acc_next;
            b      <= b_next;
            psw_hi <= psw_hi_next;
        end
    end

endmodule

//--- rtl/pointer_regs.sv
module pointer_regs (
    input  logic                      clk,
    input  logic                      reset_n,
    input  core_ctl_pkg::sfr_write_t   write,
    input  core_ctl_pkg::dptr_update_t dptr_ctl,
    input  sfr_map_pkg::stack_step_t  stack_move,
    output sfr_map_pkg::word_t        dptr,
    output sfr_map_pkg::word_t        sp,
    output sfr_map_pkg::word_t        dptr_next,
    output sfr_map_pkg::byte_t        spl_next
);

    sfr_map_pkg::word_t sp_next;
    sfr_map_pkg::word_t step_ext;
    logic               dpl_we;
    logic               dph_we;
    logic               spl_we;
    logic               sph_we;

    assign dpl_we = write.we && (write.addr == sfr_map_pkg::DPL_ADDR);
    assign dph_we = write.we && (write.addr == sfr_map_pkg::DPH_ADDR);
    assign spl_we = write.we && (write.addr == sfr_map_pkg::SPL_ADDR);
    assign sph_we = write.we && (write.addr == sfr_map_pkg::SPH_ADDR);

    // ------------------------------------------------------------------------
    // Data pointer
    // ------------------------------------------------------------------------
    always_comb begin
        dptr_next = dptr;
        if (dptr_ctl.load) begin
            dptr_next = dptr_ctl.value;
        end else if (dptr_ctl.inc) begin
            dptr_next = dptr + 16'd1;
        end else if (dpl_we) begin
            dptr_next[7:0] = write.data;
        end else if (dph_we) begin
            dptr_next[15:8] = write.data;
        end
    end

    // ------------------------------------------------------------------------
    // Stack pointer
    // ------------------------------------------------------------------------

    // Sign extend the step, the sum wraps at 16 bits
    assign step_ext = {{(sfr_map_pkg::WORD_WIDTH - sfr_map_pkg::STEP_WIDTH){stack_move[2]}},
                       stack_move};

    always_comb begin
        sp_next = sp;
        if (stack_move != '0) begin
            sp_next = sp + step_ext;
        end else if (spl_we) begin
            sp_next[7:0] = write.data;
        end else if (sph_we) begin
            sp_next[15:8] = write.data;
        end
    end

    assign spl_next = sp_next[7:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dptr <= '0;
            sp   <= sfr_map_pkg::SP_RESET;
        end else begin
            dptr <= dptr_next;
            sp   <= sp_next;
        end
    end

endmodule

//--- rtl/port_regs.sv
module port_regs (
    input  logic                    clk,
    input  logic                    reset_n,
    input  core_ctl_pkg::sfr_write_t write,
    output core_ctl_pkg::port_view_t ports
);

    // ------------------------------------------------------------------------
    // Port latches and direction bytes
    // ------------------------------------------------------------------------

    // All directions clear to input on reset
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ports <= '0;
        end else if (write.we) begin
            case (write.addr)
                sfr_map_pkg::P0_ADDR: begin
                    ports.latch[0] <= write.data;
                end
                sfr_map_pkg::P1_ADDR: begin
                    ports.latch[1] <= write.data;
                end
                sfr_map_pkg::P2_ADDR: begin
                    ports.latch[2] <= write.data;
                end
                sfr_map_pkg::P3_ADDR: begin
                    ports.latch[3] <= write.data;
                end
                sfr_map_pkg::P0_DIR_ADDR: begin
                    ports.dir[0] <= write.data;
                end
                sfr_map_pkg::P1_DIR_ADDR: begin
                    ports.dir[1] <= write.data;
                end
                sfr_map_pkg::P2_DIR_ADDR: begin
                    ports.dir[2] <= write.data;
                end
                sfr_map_pkg::P3_DIR_ADDR: begin
                    ports.dir[3] <= write.data;
                end
                default: begin
                    // Address belongs to another group
                end
            endcase
        end
    end

endmodule

//--- rtl/sfr_read_mux.sv
module sfr_read_mux (
    input  logic                         clk,
    input  logic                         reset_n,
    input  sfr_map_pkg::sfr_addr_t       read_addr,
    input  core_ctl_pkg::sfr_next_t      next_vals,
    input  sfr_map_pkg::byte_t [3:0]     pins_in,
    output sfr_map_pkg::byte_t           data_out
);

    sfr_map_pkg::byte_t read_sel;

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------

    // Register reads see the value after this edge, so a same cycle
    // write or core update shows up without a separate bypass
    always_comb begin
        case (read_addr)
            sfr_map_pkg::ACC_ADDR: begin
                read_sel = next_vals.acc;
            end
            sfr_map_pkg::B_ADDR: begin
                read_sel = next_vals.b;
            end
            sfr_map_pkg::PSW_ADDR: begin
                read_sel = next_vals.psw;
            end
            sfr_map_pkg::DPL_ADDR: begin
                read_sel = next_vals.dptr[7:0];
            end
            sfr_map_pkg::DPH_ADDR: begin
                read_sel = next_vals.dptr[15:8];
            end
            // Both SP addresses return the low byte
            sfr_map_pkg::SPL_ADDR,
            sfr_map_pkg::SPH_ADDR: begin
                read_sel = next_vals.spl;
            end
            // Ports read the pins, not the latch
            sfr_map_pkg::P0_ADDR: read_sel = pins_in[0];
            sfr_map_pkg::P1_ADDR: read_sel = pins_in[1];
            sfr_map_pkg::P2_ADDR: read_sel = pins_in[2];
            sfr_map_pkg::P3_ADDR: read_sel = pins_in[3];
            default: begin
                read_sel = '0;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Read register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_out <= '0;
        end else begin
            data_out <= read_sel;
        end
    end

endmodule

//--- rtl/sfr_bank.sv
module sfr_bank (
    input  logic                      clk,
    input  logic                      reset_n,
    input  core_ctl_pkg::sfr_write_t   write,
    input  sfr_map_pkg::sfr_addr_t    read_addr,
    input  core_ctl_pkg::alu_flags_t   flags,
    input  core_ctl_pkg::core_update_t core_ctl,
    input  core_ctl_pkg::dptr_update_t dptr_ctl,
    input  sfr_map_pkg::byte_t [3:0]  pins_in,
    output sfr_map_pkg::byte_t        data_out,
    output sfr_map_pkg::byte_t        acc,
    output sfr_map_pkg::byte_t        b,
    output sfr_map_pkg::byte_t        psw,
    output sfr_map_pkg::word_t        dptr,
    output sfr_map_pkg::word_t        sp,
    output core_ctl_pkg::port_view_t   ports
);

    // Next values gathered for the read path
    core_ctl_pkg::sfr_next_t next_vals;

    acc_psw_regs acc_psw_regs_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .write    (write),
        .flags    (flags),
        .core_ctl (core_ctl),
        .acc      (acc),
        .b        (b),
        .psw      (psw),
        .acc_next (next_vals.acc),
        .b_next   (next_vals.b),
        .psw_next (next_vals.psw)
    );

    pointer_regs pointer_regs_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .write      (write),
        .dptr_ctl   (dptr_ctl),
        .stack_move (core_ctl.stack_move),
        .dptr       (dptr),
        .sp         (sp),
        .dptr_next  (next_vals.dptr),
        .spl_next   (next_vals.spl)
    );

    port_regs port_regs_i (
        .clk     (clk),
        .reset_n (reset_n),
        .write   (write),
        .ports   (ports)
    );

    sfr_read_mux sfr_read_mux_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .read_addr (read_addr),
        .next_vals (next_vals),
        .pins_in   (pins_in),
        .data_out  (data_out)
    );

endmodule

//--- bench/sfr_bank_checker.sv
module sfr_bank_checker (
    input logic                       clk,
    input logic                       reset_n,
    input core_ctl_pkg::sfr_write_t   write,
    input core_ctl_pkg::core_update_t core_ctl,
    input sfr_map_pkg::sfr_addr_t     read_addr,
    input sfr_map_pkg::byte_t         acc,
    input sfr_map_pkg::byte_t         b,
    input sfr_map_pkg::byte_t         psw,
    input sfr_map_pkg::word_t         sp,
    input sfr_map_pkg::byte_t         data_out
);

    timeunit 1ns;
    timeprecision 1ps;

    int   failure_count;
    logic b_written;
    logic sp_touched;
    logic read_mapped;

    assign b_written   = write.we && (write.addr == sfr_map_pkg::B_ADDR);
    assign sp_touched  = (core_ctl.stack_move != '0) ||
                         (write.we && (write.addr == sfr_map_pkg::SPL_ADDR ||
                                       write.addr == sfr_map_pkg::SPH_ADDR));
    // Direction registers are write only
    assign read_mapped = read_addr inside {
        sfr_map_pkg::ACC_ADDR, sfr_map_pkg::B_ADDR, sfr_map_pkg::PSW_ADDR,
        sfr_map_pkg::DPL_ADDR, sfr_map_pkg::DPH_ADDR,
        sfr_map_pkg::SPL_ADDR, sfr_map_pkg::SPH_ADDR,
        sfr_map_pkg::P0_ADDR, sfr_map_pkg::P1_ADDR, sfr_map_pkg::P2_ADDR, sfr_map_pkg::P3_ADDR
    };

    // Parity read back through the registered read path
    parity_follows_acc: assert property (
        @(posedge clk) disable iff (!reset_n)
        (read_addr == sfr_map_pkg::PSW_ADDR) |=> (data_out[0] == ^acc)
    ) else begin
        failure_count++;
        $error("psw bit 0 read back is not the parity of acc");
    end

    b_held_without_write: assert property (
        @(posedge clk) disable iff (!reset_n) !b_written |=> $stable(b)
    ) else begin
        failure_count++;
        $error("b changed without a write to B");
    end

    sp_held_without_update: assert property (
        @(posedge clk) disable iff (!reset_n) !sp_touched |=> $stable(sp)
    ) else begin
        failure_count++;
        $error("sp changed without a stack move or SP write");
    end

    unmapped_read_zero: assert property (
        @(posedge clk) disable iff (!reset_n) !read_mapped |=> data_out == '0
    ) else begin
        failure_count++;
        $error("unmapped read returned nonzero data");
    end

endmodule

bind sfr_bank sfr_bank_checker sfr_bank_checker_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .write     (write),
    .core_ctl  (core_ctl),
    .read_addr (read_addr),
    .acc       (acc),
    .b         (b),
    .psw       (psw),
    .sp        (sp),
    .data_out  (data_out)
);

//--- bench/sfr_bank_tb.sv
module sfr_bank_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CYCLES_PER_TEST = 400;
    // Polls of 0.5 ns while waiting for one clock edge
    localparam int EDGE_TIMEOUT    = 40;

    logic                       clk;
    logic                       reset_n;
    core_ctl_pkg::sfr_write_t   write;
    sfr_map_pkg::sfr_addr_t     read_addr;
    core_ctl_pkg::alu_flags_t   flags;
    core_ctl_pkg::core_update_t core_ctl;
    core_ctl_pkg::dptr_update_t dptr_ctl;
    sfr_map_pkg::byte_t [3:0]   pins_in;
    sfr_map_pkg::byte_t         data_out;
    sfr_map_pkg::byte_t         acc;
    sfr_map_pkg::byte_t         b;
    sfr_map_pkg::byte_t         psw;
    sfr_map_pkg::word_t         dptr;
    sfr_map_pkg::word_t         sp;
    core_ctl_pkg::port_view_t   ports;

    // Reference model
    sfr_map_pkg::byte_t         m_acc;
    sfr_map_pkg::byte_t         m_b;
    logic [7:1]                 m_psw_hi;
    sfr_map_pkg::word_t         m_dptr;
    sfr_map_pkg::word_t         m_sp;
    sfr_map_pkg::byte_t [3:0]   m_latch;
    sfr_map_pkg::byte_t [3:0]   m_dir;
    sfr_map_pkg::byte_t         m_data_out;

    logic [31:0]                rng_state;
    int                         cycle_count;
    realtime                    edge_time;
    int                         error_count;
    int                         check_count;
    int                         assert_failures;

    // Writable addresses grouped by block: ACC B PSW, DPTR, SP, latches, directions
    sfr_map_pkg::sfr_addr_t mapped_list [15] = '{
        sfr_map_pkg::ACC_ADDR, sfr_map_pkg::B_ADDR, sfr_map_pkg::PSW_ADDR,
        sfr_map_pkg::DPL_ADDR, sfr_map_pkg::DPH_ADDR,
        sfr_map_pkg::SPL_ADDR, sfr_map_pkg::SPH_ADDR,
        sfr_map_pkg::P0_ADDR, sfr_map_pkg::P1_ADDR, sfr_map_pkg::P2_ADDR, sfr_map_pkg::P3_ADDR,
        sfr_map_pkg::P0_DIR_ADDR, sfr_map_pkg::P1_DIR_ADDR,
        sfr_map_pkg::P2_DIR_ADDR, sfr_map_pkg::P3_DIR_ADDR
    };

    sfr_bank sfr_bank_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .write     (write),
        .read_addr (read_addr),
        .flags     (flags),
        .core_ctl  (core_ctl),
        .dptr_ctl  (dptr_ctl),
        .pins_in   (pins_in),
        .data_out  (data_out),
        .acc       (acc),
        .b         (b),
        .psw       (psw),
        .dptr      (dptr),
        .sp        (sp),
        .ports     (ports)
    );

    // 8 ns clock, edge time kept for aligning the stimulus
    initial begin
        clk = 1'b0;
        forever begin
            #4;
            clk = 1'b1;
            edge_time = $realtime;
            cycle_count = cycle_count + 1;
            #4;
            clk = 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        // Upper bits first, the low LCG bits have short periods
        return {rng_state[15:0], rng_state[31:16]};
    endfunction

    function automatic bit chance(input int pct);
        logic [31:0] r;
        r = next_random();
        return (r % 100) < pct;
    endfunction

    function automatic sfr_map_pkg::sfr_addr_t pick_addr(input int lo, input int hi);
        logic [31:0] r;
        r = next_random();
        return mapped_list[lo + int'(r % (hi - lo + 1))];
    endfunction

    function automatic bit write_hits(input sfr_map_pkg::sfr_addr_t addr);
        return write.we && (write.addr == addr);
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display(">>> FAIL");
        $finish;
    endtask

    // Returns 1 ns after the next rising edge
    task automatic next_cycle();
        int start;
        int polls;
        start = cycle_count;
        polls = 0;
        while (cycle_count == start) begin
            if (polls >= EDGE_TIMEOUT) begin
                abort_on_timeout("no rising clock edge seen");
            end
            #0.5;
            polls++;
        end
        #(edge_time + 1.0 - $realtime);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus and model
    // ------------------------------------------------------------------------
    task automatic drive_stimulus(input int test);
        logic [31:0] r;
        int lo;
        int hi;
        lo = 0;
        hi = 14;
        core_ctl = '0;
        dptr_ctl = '0;
        r = next_random();
        flags = r[2:0];
        pins_in = next_random();
        r = next_random();
        write.we   = r[0];
        write.data = r[15:8];
        case (test)
            3: begin
                lo = 0;
                hi = 2;
                core_ctl.load_a          = chance(30);
                core_ctl.a_value         = r[23:16];
                core_ctl.psw_flag_update = chance(25);
                core_ctl.rlc_a           = chance(25);
                core_ctl.rrc_a           = chance(25);
                core_ctl.cy_update       = chance(25);
            end
            4: begin
                lo = 3;
                hi = 4;
                dptr_ctl.load = chance(15);
                dptr_ctl.inc  = chance(50);
                // Loads near FFFF make the wrap to 0000 frequent
                dptr_ctl.value = r[24] ? (16'hFFFC | r[26:25]) : r[31:16];
            end
            5: begin
                lo = 5;
                hi = 6;
                if (chance(60)) begin
                    core_ctl.stack_move = r[18:16];
                end
            end
            6: begin
                lo = 7;
                hi = 14;
            end
            default: begin
            end
        endcase
        write.addr = pick_addr(lo, hi);
        r = next_random();
        case (r[1:0])
            2'd0: read_addr = write.addr;
            2'd1: read_addr = r[15:8];
            default: read_addr = pick_addr(lo, hi);
        endcase
        // Reset check runs with the bank idle
        if (test == 1) begin
            write.we = 1'b0;
        end
    endtask

    // Applies the inputs still held after the edge to the model state
    task automatic update_model();
        int step;
        step = $signed(core_ctl.stack_move);
        // PSW first, rotates take the carry from the old ACC
        if (write_hits(sfr_map_pkg::PSW_ADDR)) begin
            m_psw_hi = write.data[7:1];
        end else if (core_ctl.psw_flag_update) begin
            m_psw_hi[7] = flags.cy;
            m_psw_hi[6] = flags.ac;
            m_psw_hi[2] = flags.ov;
        end else if (core_ctl.rlc_a) begin
            m_psw_hi[7] = m_acc[7];
        end else if (core_ctl.rrc_a) begin
            m_psw_hi[7] = m_acc[0];
        end else if (core_ctl.cy_update) begin
            m_psw_hi[7] = flags.cy;
        end
        if (core_ctl.load_a) begin
            m_acc = core_ctl.a_value;
        end else if (write_hits(sfr_map_pkg::ACC_ADDR)) begin
            m_acc = write.data;
        end
        if (write_hits(sfr_map_pkg::B_ADDR)) begin
            m_b = write.data;
        end
        if (dptr_ctl.load) begin
            m_dptr = dptr_ctl.value;
        end else if (dptr_ctl.inc) begin
            m_dptr = m_dptr + 16'd1;
        end else if (write_hits(sfr_map_pkg::DPL_ADDR)) begin
            m_dptr[7:0] = write.data;
        end else if (write_hits(sfr_map_pkg::DPH_ADDR)) begin
            m_dptr[15:8] = write.data;
        end
        if (step != 0) begin
            m_sp = m_sp + step[15:0];
        end else if (write_hits(sfr_map_pkg::SPL_ADDR)) begin
            m_sp[7:0] = write.data;
        end else if (write_hits(sfr_map_pkg::SPH_ADDR)) begin
            m_sp[15:8] = write.data;
        end
        m_data_out = '0;
        case (read_addr)
            sfr_map_pkg::ACC_ADDR: m_data_out = m_acc;
            sfr_map_pkg::B_ADDR:   m_data_out = m_b;
            sfr_map_pkg::PSW_ADDR: m_data_out = {m_psw_hi, ^m_acc};
            sfr_map_pkg::DPL_ADDR: m_data_out = m_dptr[7:0];
            sfr_map_pkg::DPH_ADDR: m_data_out = m_dptr[15:8];
            sfr_map_pkg::SPL_ADDR: m_data_out = m_sp[7:0];
            sfr_map_pkg::SPH_ADDR: m_data_out = m_sp[7:0];
            default: begin
            end
        endcase
        for (int i = 0; i < 4; i++) begin
            if (write_hits(mapped_list[7 + i])) begin
                m_latch[i] = write.data;
            end
            if (write_hits(mapped_list[11 + i])) begin
                m_dir[i] = write.data;
            end
            // Port reads see the pins at the read edge
            if (read_addr == mapped_list[7 + i]) begin
                m_data_out = pins_in[i];
            end
        end
    endtask

    task automatic compare_outputs();
        check_value("acc", m_acc, acc);
        check_value("b", m_b, b);
        check_value("psw", {m_psw_hi, ^m_acc}, psw);
        check_value("dptr", m_dptr, dptr);
        check_value("sp", m_sp, sp);
        check_value("ports", {m_latch, m_dir}, ports);
        check_value("data_out", m_data_out, data_out);
    endtask

    task automatic run_test(input int test, input string name, input int cycles);
        int errors_before;
        errors_before = error_count;
        compare_outputs();
        for (int i = 0; i < cycles; i++) begin
            drive_stimulus(test);
            next_cycle();
            update_model();
            compare_outputs();
        end
        $display("Test %0d (%s): %0d cycles, %0d errors",
                 test, name, cycles, error_count - errors_before);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        rng_state   = 32'hd15a1df4;
        error_count = 0;
        check_count = 0;
        reset_n     = 1'b0;
        write       = '0;
        read_addr   = '0;
        flags       = '0;
        core_ctl    = '0;
        dptr_ctl    = '0;
        pins_in     = '0;
        m_acc       = '0;
        m_b         = '0;
        m_psw_hi    = '0;
        m_dptr      = '0;
        m_sp        = sfr_map_pkg::SP_RESET;
        m_latch     = '0;
        m_dir       = '0;
        m_data_out  = '0;
        for (int i = 0; i < 10; i++) begin
            next_cycle();
        end
        reset_n = 1'b1;

        run_test(1, "reset values", 4);
        run_test(2, "random writes and reads", CYCLES_PER_TEST);
        run_test(3, "accumulator and status", CYCLES_PER_TEST);
        run_test(4, "data pointer", CYCLES_PER_TEST);
        run_test(5, "stack pointer", CYCLES_PER_TEST);
        run_test(6, "ports", CYCLES_PER_TEST);

        assert_failures = sfr_bank_i.sfr_bank_checker_i.failure_count;
        $display("Done: 6 tests, %0d checks, %0d errors, %0d assertion failures",
                 check_count, error_count, assert_failures);
        if (error_count == 0 && assert_failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/sfr_map_pkg.sv
rtl/core_ctl_pkg.sv
rtl/acc_psw_regs.sv
rtl/pointer_regs.sv
rtl/port_regs.sv
rtl/sfr_read_mux.sv
rtl/sfr_bank.sv
bench/sfr_bank_checker.sv
bench/sfr_bank_tb.sv
